// ==== design/tune_pkg.sv ====
package tune_pkg;

    ////////////////////////////////////////
    // Score geometry
    ////////////////////////////////////////

    localparam int period_w = 22;
    localparam int steps    = 32;
    localparam int step_w   = 5;
    localparam int voices   = 2;
    localparam int addr_w   = 6;  // Voice index in the top bit, step number below.

    ////////////////////////////////////////
    // Notes
    ////////////////////////////////////////

    // Low octave first, then the middle and high octaves.
    typedef enum logic [4:0] {
        rest,
        lal,
        sil,
        do_n,
        re,
        mi,
        fa,
        so,
        la,
        si,
        doh,
        reh,
        mih,
        fah,
        soh,
        lah,
        sih
    } note_e;

    // Tone period in tempo_clk cycles for each pitch. A rest has no tone.
    function automatic logic [period_w-1:0] note_period(input note_e n);
        case (n)
            lal:     return 22'd227273;
            sil:     return 22'd204082;
            do_n:    return 22'd191571;
            re:      return 22'd170648;
            mi:      return 22'd151976;
            fa:      return 22'd143266;
            so:      return 22'd127877;
            la:      return 22'd113636;
            si:      return 22'd101419;
            doh:     return 22'd95420;
            reh:     return 22'd85034;
            mih:     return 22'd75757;
            fah:     return 22'd71633;
            soh:     return 22'd63776;
            lah:     return 22'd56818;
            sih:     return 22'd50607;
            default: return '0;
        endcase
    endfunction

endpackage

// ==== design/score_bus_if.sv ====
interface score_bus_if;
    import tune_pkg::*;

    logic              req;    // Held by the voice until grant.
    logic [addr_w-1:0] addr;
    logic              grant;  // One-cycle pulse.
    logic              valid;  // One cycle after grant.
    note_e             note;

    modport voice (
        output req,
        output addr,
        input  grant,
        input  valid,
        input  note
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output valid,
        output note
    );

endinterface

// ==== design/beat_timer.sv ====
module beat_timer #(
    parameter int unsigned beat_cycles = 25_000_000
) (
    input  logic tempo_clk,
    input  logic rst_n,
    input  logic play,
    output logic beat
);

    localparam int cnt_w = (beat_cycles > 1) ? $clog2(beat_cycles) : 1;

    logic [cnt_w-1:0] count;

    // The count only runs while playing, so the first beat lands a full
    // beat after play rises.
    always_ff @(posedge tempo_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            beat  <= 1'b0;
        end else if (!play) begin
            count <= '0;
            beat  <= 1'b0;
        end else if (count == cnt_w'(beat_cycles - 1)) begin
            count <= '0;
            beat  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            beat  <= 1'b0;
        end
    end

endmodule

// ==== design/score_rom.sv ====
module score_rom (
    input  logic                      tempo_clk,
    input  logic                      rd,
    input  logic [tune_pkg::addr_w-1:0] addr,
    output tune_pkg::note_e           note
);
    import tune_pkg::*;

    localparam int depth = voices * steps;

    note_e word;

    ////////////////////////////////////////
    // Score table
    ////////////////////////////////////////

    always_comb begin
        case (addr) inside
            // Voice 0, the melody.
            6'd0:  word = si;
            6'd1:  word = la;
            6'd2:  word = so;
            6'd3:  word = la;
            6'd4:  word = si;
            6'd5:  word = si;
            6'd6:  word = si;
            6'd7:  word = si;
            6'd8:  word = la;
            6'd9:  word = la;
            6'd10: word = la;
            6'd11: word = la;
            6'd12: word = si;
            6'd13: word = si;
            6'd14: word = si;
            6'd15: word = si;
            6'd16: word = si;
            6'd17: word = la;
            6'd18: word = so;
            6'd19: word = la;
            6'd20: word = si;
            6'd21: word = si;
            6'd22: word = si;
            6'd23: word = si;
            6'd24: word = la;
            6'd25: word = la;
            6'd26: word = si;
            6'd27: word = la;
            6'd28: word = so;
            6'd29: word = so;
            6'd30: word = so;
            6'd31: word = so;
            // Voice 1, the accompaniment. So for the first half, Mi for the second.
            [6'd32:6'd47]: word = so;
            [6'd48:addr_w'(depth - 1)]: word = mi;
            default: word = rest;
        endcase
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    always_ff @(posedge tempo_clk) begin
        if (rd) begin
            note <= word;  // Data is back one cycle after the read.
        end
    end

endmodule

// ==== design/score_arbiter.sv ====
module score_arbiter (
    input  logic                        tempo_clk,
    input  logic                        rst_n,
    score_bus_if.arbiter                left_bus,
    score_bus_if.arbiter                right_bus,
    output logic                        rom_rd,
    output logic [tune_pkg::addr_w-1:0] rom_addr,
    input  tune_pkg::note_e             rom_note
);
    import tune_pkg::*;

    logic pick_left;
    logic pick_right;
    logic last_right;  // Voice served most recently.

    // On a tie the voice that was not served last goes first.
    assign pick_left  = left_bus.req && (!right_bus.req || last_right);
    assign pick_right = right_bus.req && !pick_left;

    assign rom_rd   = pick_left || pick_right;
    assign rom_addr = pick_left ? left_bus.addr : right_bus.addr;

    assign left_bus.grant  = pick_left;
    assign right_bus.grant = pick_right;

    // Both buses see the ROM word, only the served one gets valid.
    assign left_bus.note  = rom_note;
    assign right_bus.note = rom_note;

    always_ff @(posedge tempo_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_right <= 1'b1;  // Left has priority out of reset.
        end else if (rom_rd) begin
            last_right <= pick_right;
        end
    end

    always_ff @(posedge tempo_clk or negedge rst_n) begin
        if (!rst_n) begin
            left_bus.valid  <= 1'b0;
            right_bus.valid <= 1'b0;
        end else begin
            left_bus.valid  <= pick_left;
            right_bus.valid <= pick_right;
        end
    end

endmodule

// ==== design/voice_sequencer.sv ====
module voice_sequencer #(
    parameter int voice_index = 0
) (
    input  logic                          tempo_clk,
    input  logic                          rst_n,
    input  logic                          beat,
    score_bus_if.voice                    bus,
    output logic [tune_pkg::period_w-1:0] tune
);
    import tune_pkg::*;

    localparam logic [addr_w-step_w-1:0] voice_bits = (addr_w - step_w)'(voice_index);

    typedef enum logic [1:0] {
        idle,
        request,
        wait_note
    } state_e;

    state_e            state;
    logic [step_w-1:0] step;

    assign bus.req  = (state == request);
    assign bus.addr = {voice_bits, step};

    ////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////

    always_ff @(posedge tempo_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:      if (beat) state <= request;
                request:   if (bus.grant) state <= wait_note;
                wait_note: if (bus.valid) state <= idle;
                default:   state <= idle;
            endcase
        end
    end

    // Tune and step move together when the note comes back.
    always_ff @(posedge tempo_clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
            tune <= '0;
        end else if (state == wait_note && bus.valid) begin
            tune <= note_period(bus.note);
            step <= step + 1'b1;  // Wraps from 31 to 0.
        end
    end

endmodule

// ==== design/tone_gen.sv ====
module tone_gen #(
    parameter int unsigned div_shift = 0
) (
    input  logic                          tempo_clk,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic [tune_pkg::period_w-1:0] period,
    output logic                          spk
);
    import tune_pkg::*;

    logic [period_w-1:0] half;
    logic [period_w-1:0] count;
    logic [period_w-1:0] period_q;

    assign half = period >> div_shift;  // Cycles between two toggles.

    always_ff @(posedge tempo_clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            period_q <= '0;
            spk      <= 1'b0;
        end else begin
            period_q <= period;
            if (!enable || half == '0) begin
                count <= '0;
                spk   <= 1'b0;  // Silent while paused or on a rest.
            end else if (period != period_q) begin
                count <= '0;
            end else if (count == half - 1'b1) begin
                count <= '0;
                spk   <= ~spk;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== design/music_top.sv ====
module music_top #(
    parameter int unsigned beat_cycles = 25_000_000,
    parameter int unsigned div_shift   = 0
) (
    input  logic                          tempo_clk,
    input  logic                          rst_n,
    input  logic                          play,
    output logic [tune_pkg::period_w-1:0] tune_left,
    output logic [tune_pkg::period_w-1:0] tune_right,
    output logic                          spk_left,
    output logic                          spk_right
);
    import tune_pkg::*;

    logic              beat;
    logic              rom_rd;
    logic [addr_w-1:0] rom_addr;
    note_e             rom_note;

    score_bus_if left_bus ();
    score_bus_if right_bus ();

    ////////////////////////////////////////
    // Beat and score access
    ////////////////////////////////////////

    beat_timer #(
        .beat_cycles(beat_cycles)
    ) u_beat_timer (
        .tempo_clk(tempo_clk),
        .rst_n    (rst_n),
        .play     (play),
        .beat     (beat)
    );

    score_arbiter u_score_arbiter (
        .tempo_clk(tempo_clk),
        .rst_n    (rst_n),
        .left_bus (left_bus),
        .right_bus(right_bus),
        .rom_rd   (rom_rd),
        .rom_addr (rom_addr),
        .rom_note (rom_note)
    );

    score_rom u_score_rom (
        .tempo_clk(tempo_clk),
        .rd       (rom_rd),
        .addr     (rom_addr),
        .note     (rom_note)
    );

    ////////////////////////////////////////
    // Voices
    ////////////////////////////////////////

    voice_sequencer #(.voice_index(0)) u_seq_left (
        .tempo_clk(tempo_clk),
        .rst_n    (rst_n),
        .beat     (beat),
        .bus      (left_bus),
        .tune     (tune_left)
    );

    voice_sequencer #(.voice_index(1)) u_seq_right (
        .tempo_clk(tempo_clk),
        .rst_n    (rst_n),
        .beat     (beat),
        .bus      (right_bus),
        .tune     (tune_right)
    );

    // Both speakers fall silent while play is low.
    tone_gen #(.div_shift(div_shift)) u_tone_left (
        .tempo_clk(tempo_clk),
        .rst_n    (rst_n),
        .enable   (play),
        .period   (tune_left),
        .spk      (spk_left)
    );

    tone_gen #(.div_shift(div_shift)) u_tone_right (
        .tempo_clk(tempo_clk),
        .rst_n    (rst_n),
        .enable   (play),
        .period   (tune_right),
        .spk      (spk_right)
    );

endmodule

// ==== tests/music_checks.svh ====
`ifndef MUSIC_CHECKS_SVH
`define MUSIC_CHECKS_SVH

int err_count;      // Wrong values over the whole run.
int tests_run;
int tests_failed;
int errs_at_start;
bit hung;           // Set when a wait runs out of time.

task automatic period_check(input string what, input logic [period_w-1:0] got,
                            input logic [period_w-1:0] exp);
    if (got !== exp) begin
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        err_count++;
    end
endtask

task automatic level_check(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        err_count++;
    end
endtask

// One cycle either way is allowed for the toggle spacing.
task automatic interval_check(input string what, input int got, input int exp);
    if (got < exp - 1 || got > exp + 1) begin
        $display("ERR %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
        err_count++;
    end
endtask

task automatic begin_test();
    errs_at_start = err_count;
endtask

task automatic end_test(input string name);
    tests_run++;
    if (hung) begin
        tests_failed++;
        $display("%s: stopped by a timeout", name);
    end else if (err_count != errs_at_start) begin
        tests_failed++;
        $display("%s: FAILED with %0d errors", name, err_count - errs_at_start);
    end else begin
        $display("%s: ok", name);
    end
endtask

`endif

// ==== tests/music_tb.sv ====
module music_tb #(
    parameter int unsigned beat_cycles = 2000,
    parameter int unsigned div_shift   = 10
);
    import tune_pkg::*;

    localparam int beat_limit   = beat_cycles + 20;  // Cycles allowed for one beat.
    localparam int toggle_limit = 600;

    logic                tempo_clk;
    logic                rst_n;
    logic                play;
    logic [period_w-1:0] tune_left;
    logic [period_w-1:0] tune_right;
    logic                spk_left;
    logic                spk_right;

    int played;  // Tune updates seen since reset.

    note_e melody [steps] = '{si, la, so, la, si, si, si, si, la, la, la, la, si, si, si, si,
                              si, la, so, la, si, si, si, si, la, la, si, la, so, so, so, so};
    note_e accomp [steps] = '{so, so, so, so, so, so, so, so, so, so, so, so, so, so, so, so,
                              mi, mi, mi, mi, mi, mi, mi, mi, mi, mi, mi, mi, mi, mi, mi, mi};

    `include "music_checks.svh"

    music_top #(
        .beat_cycles(beat_cycles),
        .div_shift  (div_shift)
    ) dut_i (
        .tempo_clk (tempo_clk),
        .rst_n     (rst_n),
        .play      (play),
        .tune_left (tune_left),
        .tune_right(tune_right),
        .spk_left  (spk_left),
        .spk_right (spk_right)
    );

    initial begin
        tempo_clk = 1'b0;
        forever #50 tempo_clk = ~tempo_clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge tempo_clk);
        @(negedge tempo_clk);  // Inputs change and outputs are read here.
    endtask

    task automatic await_beat();
        int n;
        n = 0;
        while (!dut_i.beat && n < beat_limit) begin
            next_cycle();
            n++;
        end
        if (!dut_i.beat) begin
            $display("Timed out: no beat came within %0d cycles", beat_limit);
            hung = 1'b1;
        end
    endtask

    // Counts cycles until the chosen speaker changes level.
    task automatic next_toggle(input bit use_right, output int cycles);
        logic start;
        start  = use_right ? spk_right : spk_left;
        cycles = 0;
        while ((use_right ? spk_right : spk_left) == start && cycles < toggle_limit) begin
            next_cycle();
            cycles++;
        end
        if ((use_right ? spk_right : spk_left) == start) begin
            $display("Timed out: the %s speaker did not toggle within %0d cycles",
                     use_right ? "right" : "left", toggle_limit);
            hung = 1'b1;
        end
    endtask

    task automatic quiet_outputs(input string when);
        period_check({"tune_left ", when}, tune_left, '0);
        period_check({"tune_right ", when}, tune_right, '0);
        level_check({"spk_left ", when}, spk_left, 1'b0);
        level_check({"spk_right ", when}, spk_right, 1'b0);
    endtask

    task automatic play_step();
        int idx;
        idx = played % steps;
        await_beat();
        if (hung) return;
        repeat (4) next_cycle();  // Both tunes settle within four cycles of a beat.
        period_check($sformatf("tune_left step %0d", idx), tune_left,
                     note_period(melody[idx]));
        period_check($sformatf("tune_right step %0d", idx), tune_right,
                     note_period(accomp[idx]));
        played++;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reset_values();
        rst_n = 1'b0;
        play  = 1'b0;
        repeat (3) begin
            @(negedge tempo_clk);
            quiet_outputs("in reset");
        end
        rst_n = 1'b1;
        next_cycle();
        quiet_outputs("after reset");
        played = 0;
    endtask

    task automatic melody_order();
        play = 1'b1;
        for (int k = 0; k < steps; k++) begin
            play_step();
            if (hung) return;
        end
    endtask

    task automatic score_wrap();
        play_step();  // Step 0 comes round again.
    endtask

    task automatic pitch_interval();
        int idx;
        int first;
        int interval;
        idx = (played - 1) % steps;
        next_toggle(1'b0, first);
        if (hung) return;
        next_toggle(1'b0, interval);
        if (hung) return;
        interval_check("left toggle interval", interval,
                       int'(note_period(melody[idx]) >> div_shift));
        next_toggle(1'b1, first);
        if (hung) return;
        next_toggle(1'b1, interval);
        if (hung) return;
        interval_check("right toggle interval", interval,
                       int'(note_period(accomp[idx]) >> div_shift));
    endtask

    task automatic pause_resume();
        int                  idx;
        logic [period_w-1:0] held_left;
        logic [period_w-1:0] held_right;
        idx        = (played - 1) % steps;  // The last step played keeps sounding.
        held_left  = note_period(melody[idx]);
        held_right = note_period(accomp[idx]);
        play = 1'b0;
        next_cycle();
        for (int n = 0; n < 2 * beat_cycles + 50; n++) begin
            next_cycle();
            period_check("tune_left while paused", tune_left, held_left);
            period_check("tune_right while paused", tune_right, held_right);
            level_check("spk_left while paused", spk_left, 1'b0);
            level_check("spk_right while paused", spk_right, 1'b0);
        end
        play = 1'b1;
        play_step();  // Picks up at the step after the last one played.
    endtask

    initial begin
        rst_n = 1'b0;
        play  = 1'b0;
        begin_test();
        reset_values();
        end_test("reset");
        if (!hung) begin
            begin_test();
            melody_order();
            end_test("melody order");
        end
        if (!hung) begin
            begin_test();
            score_wrap();
            end_test("wrap");
        end
        if (!hung) begin
            begin_test();
            pitch_interval();
            end_test("pitch");
        end
        if (!hung) begin
            begin_test();
            pause_resume();
            end_test("pause and resume");
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (hung || err_count != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tests
design/tune_pkg.sv
design/score_bus_if.sv
design/beat_timer.sv
design/score_rom.sv
design/score_arbiter.sv
design/voice_sequencer.sv
design/tone_gen.sv
design/music_top.sv
tests/music_tb.sv
